/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_bits = 5;
  localparam int reg_count = 1 << reg_bits;
  localparam int csr_bits = 12;

  typedef logic [xlen-1:0] inst_t;
  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen-1:0] pc_t;
  typedef logic [reg_bits-1:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [csr_bits-1:0] csr_addr_t;
  typedef logic [6:0] opcode_t;

  // base opcodes in bits [6:0]
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

`default_nettype wire

/* hdl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  // alu class only, execute refines it with funct3
  typedef enum logic [1:0] {
    alu_add     = 2'd0,
    alu_sub_cmp = 2'd1,  // sub, sra and branch compares
    alu_funct   = 2'd2,
    alu_pass_b  = 2'd3
  } alu_op_e;

  typedef enum logic [1:0] {
    src_a_rs1  = 2'd0,
    src_a_pc   = 2'd1,
    src_a_zero = 2'd2
  } src_a_e;

  typedef enum logic [1:0] {
    src_b_rs2  = 2'd0,
    src_b_imm  = 2'd1,
    src_b_four = 2'd2
  } src_b_e;

  typedef enum logic [1:0] {
    wb_alu      = 2'd0,
    wb_mem      = 2'd1,
    wb_pc_plus4 = 2'd2,
    wb_csr      = 2'd3
  } wb_sel_e;

  typedef enum logic [1:0] {
    st_run    = 2'd0,
    st_stall  = 2'd1,  // load in the output slot
    st_squash = 2'd2   // redirect cycle
  } stage_state_e;

endpackage

`default_nettype wire

/* hdl/decode_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface decode_ctrl_if;
  import decode_pkg::*;

  alu_op_e alu_op;
  src_a_e  src_a;
  src_b_e  src_b;
  wb_sel_e wb_sel;
  logic    reg_we;
  logic    mem_read;
  logic    mem_write;
  logic    branch;
  logic    jump;
  logic    jalr;
  logic    uses_rs1;  // rs1 field really read
  logic    uses_rs2;
  logic    csr_we;

  modport decoder (
    output alu_op, src_a, src_b, wb_sel, reg_we, mem_read, mem_write,
           branch, jump, jalr, uses_rs1, uses_rs2, csr_we
  );

  modport stage (
    input alu_op, src_a, src_b, wb_sel, reg_we, mem_read, mem_write,
          branch, jump, jalr, uses_rs1, uses_rs2, csr_we
  );

endinterface

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data
);
  import rv_isa_pkg::*;

  word_t regs [reg_count];

  // x0 reads zero, a write in the same cycle shows through
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we && idx == rd) begin
      return rd_data;
    end else begin
      return regs[idx];
    end
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // writes to x0 dropped
      regs[rd] <= rd_data;
    end
  end

  x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
    we |=> regs[0] == '0);

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
  input  rv_isa_pkg::inst_t instr,
  output rv_isa_pkg::word_t imm
);
  import rv_isa_pkg::*;

  opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      op_jalr, op_load, op_imm: begin  // i-type
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      op_store: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      op_branch: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
               instr[11:8], 1'b0};
      end
      op_lui, op_auipc: begin
        imm = {instr[31:12], 12'b0};
      end
      op_jal: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
               instr[30:21], 1'b0};
      end
      default: imm = '0;  // r-type, system and unknown
    endcase
  end

endmodule

`default_nettype wire

/* hdl/branch_compare.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_compare (
  input  rv_isa_pkg::inst_t instr,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t rs2_data,
  output logic              taken
);
  import rv_isa_pkg::*;

  funct3_t funct3;
  logic    eq;
  logic    lt_s;
  logic    lt_u;

  assign funct3 = instr[14:12];
  assign eq     = rs1_data == rs2_data;
  assign lt_s   = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u   = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt_s;
      f3_bge:  taken = !lt_s;
      f3_bltu: taken = lt_u;
      f3_bgeu: taken = !lt_u;
      default: taken = 1'b0;  // 010 and 011 undefined
    endcase
  end

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input rv_isa_pkg::inst_t instr,
  decode_ctrl_if.decoder   ctrl
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic    alt;  // funct7 bit 5

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  always_comb begin
    // nop with every enable low
    ctrl.alu_op    = alu_add;
    ctrl.src_a     = src_a_rs1;
    ctrl.src_b     = src_b_rs2;
    ctrl.wb_sel    = wb_alu;
    ctrl.reg_we    = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.jalr      = 1'b0;
    ctrl.uses_rs1  = 1'b0;
    ctrl.uses_rs2  = 1'b0;
    ctrl.csr_we    = 1'b0;
    case (opcode)
      op_lui: begin
        ctrl.alu_op = alu_pass_b;
        ctrl.src_a  = src_a_zero;
        ctrl.src_b  = src_b_imm;
        ctrl.reg_we = 1'b1;
      end
      op_auipc: begin
        ctrl.src_a  = src_a_pc;
        ctrl.src_b  = src_b_imm;
        ctrl.reg_we = 1'b1;
      end
      op_jal, op_jalr: begin
        ctrl.src_a    = src_a_pc;  // link value pc + 4
        ctrl.src_b    = src_b_four;
        ctrl.wb_sel   = wb_pc_plus4;
        ctrl.reg_we   = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.jalr     = opcode == op_jalr;
        ctrl.uses_rs1 = opcode == op_jalr;
      end
      op_branch: begin
        ctrl.alu_op   = alu_sub_cmp;
        ctrl.branch   = 1'b1;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
      end
      op_load: begin
        ctrl.src_b    = src_b_imm;
        ctrl.wb_sel   = wb_mem;
        ctrl.reg_we   = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.uses_rs1 = 1'b1;
      end
      op_store: begin
        ctrl.src_b     = src_b_imm;
        ctrl.mem_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
      end
      op_imm: begin
        ctrl.alu_op   = alu_funct;  // srai keeps bit 30 in imm
        ctrl.src_b    = src_b_imm;
        ctrl.reg_we   = 1'b1;
        ctrl.uses_rs1 = 1'b1;
      end
      op_reg: begin
        ctrl.alu_op   = alt ? alu_sub_cmp : alu_funct;
        ctrl.reg_we   = 1'b1;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
      end
      op_system: begin
        if (funct3 != 3'b000) begin  // csr ops, ecall and ebreak stay nop
          ctrl.wb_sel   = wb_csr;
          ctrl.reg_we   = 1'b1;
          ctrl.csr_we   = 1'b1;
          ctrl.uses_rs1 = !funct3[2];  // immediate forms read no register
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/decode_control.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  rv_isa_pkg::pc_t       in_pc,
  input  rv_isa_pkg::inst_t     in_instr,
  decode_ctrl_if.stage          ctrl,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  input  rv_isa_pkg::word_t     imm,
  input  logic                  taken,
  output logic                  out_valid,
  input  logic                  out_ready,
  output rv_isa_pkg::pc_t       out_pc,
  output rv_isa_pkg::word_t     out_rs1_data,
  output rv_isa_pkg::word_t     out_rs2_data,
  output rv_isa_pkg::word_t     out_imm,
  output rv_isa_pkg::reg_idx_t  out_rd,
  output rv_isa_pkg::funct3_t   out_funct3,
  output decode_pkg::alu_op_e   out_alu_op,
  output decode_pkg::src_a_e    out_src_a,
  output decode_pkg::src_b_e    out_src_b,
  output decode_pkg::wb_sel_e   out_wb_sel,
  output logic                  out_reg_we,
  output logic                  out_mem_read,
  output logic                  out_mem_write,
  output logic                  out_csr_we,
  output rv_isa_pkg::csr_addr_t out_csr_addr,
  output logic                  redirect_valid,
  output rv_isa_pkg::pc_t       redirect_pc
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  stage_state_e state;
  stage_state_e state_next;
  stage_state_e entry_state;
  logic         slot_free;
  logic         load_dep;
  logic         accept;
  logic         keep;
  logic         redirect_now;
  reg_idx_t     in_rs1;
  reg_idx_t     in_rs2;
  reg_idx_t     in_rd;
  pc_t          target;

  assign in_rs1 = in_instr[19:15];
  assign in_rs2 = in_instr[24:20];
  assign in_rd  = in_instr[11:7];

  assign slot_free = !out_valid || out_ready;

  // incoming word reads the rd of the load still in the slot
  assign load_dep = state == st_stall &&
                    ((ctrl.uses_rs1 && in_rs1 == out_rd) ||
                     (ctrl.uses_rs2 && in_rs2 == out_rd));

  assign in_ready = slot_free && !load_dep && !reset;
  assign accept   = in_valid && in_ready;
  assign keep     = accept && state != st_squash;  // wrong-path word dropped

  assign redirect_now = ctrl.jump || (ctrl.branch && taken);
  assign target       = (ctrl.jalr ? rs1_data : in_pc) + imm;

  always_comb begin
    if (redirect_now) begin
      entry_state = st_squash;
    end else if (ctrl.mem_read && in_rd != '0) begin
      entry_state = st_stall;
    end else begin
      entry_state = st_run;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_squash: state_next = st_run;  // lasts one cycle
      default: begin
        if (keep) begin
          state_next = entry_state;
        end else if (out_ready) begin
          state_next = st_run;  // slot drains
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= st_run;
      out_valid      <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      state          <= state_next;
      redirect_valid <= keep && redirect_now;
      if (keep) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      out_pc        <= in_pc;
      out_rs1_data  <= rs1_data;
      out_rs2_data  <= rs2_data;
      out_imm       <= imm;
      out_rd        <= in_rd;
      out_funct3    <= in_instr[14:12];
      out_alu_op    <= ctrl.alu_op;
      out_src_a     <= ctrl.src_a;
      out_src_b     <= ctrl.src_b;
      out_wb_sel    <= ctrl.wb_sel;
      out_reg_we    <= ctrl.reg_we;
      out_mem_read  <= ctrl.mem_read;
      out_mem_write <= ctrl.mem_write;
      out_csr_we    <= ctrl.csr_we;
      out_csr_addr  <= in_instr[31:20];
      redirect_pc   <= {target[31:1], target[0] & !ctrl.jalr};  // jalr clears bit 0
    end
  end

  bundle_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid &&
      $stable({out_pc, out_rs1_data, out_rs2_data, out_imm, out_rd, out_funct3,
               out_alu_op, out_src_a, out_src_b, out_wb_sel, out_reg_we,
               out_mem_read, out_mem_write, out_csr_we, out_csr_addr}));

  redirect_one_cycle: assert property (@(posedge clk) disable iff (reset)
    redirect_valid |=> !redirect_valid);

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  rv_isa_pkg::pc_t       in_pc,
  input  rv_isa_pkg::inst_t     in_instr,
  input  logic                  wb_we,
  input  rv_isa_pkg::reg_idx_t  wb_rd,
  input  rv_isa_pkg::word_t     wb_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output rv_isa_pkg::pc_t       out_pc,
  output rv_isa_pkg::word_t     out_rs1_data,
  output rv_isa_pkg::word_t     out_rs2_data,
  output rv_isa_pkg::word_t     out_imm,
  output rv_isa_pkg::reg_idx_t  out_rd,
  output rv_isa_pkg::funct3_t   out_funct3,
  output decode_pkg::alu_op_e   out_alu_op,
  output decode_pkg::src_a_e    out_src_a,
  output decode_pkg::src_b_e    out_src_b,
  output decode_pkg::wb_sel_e   out_wb_sel,
  output logic                  out_reg_we,
  output logic                  out_mem_read,
  output logic                  out_mem_write,
  output logic                  out_csr_we,
  output rv_isa_pkg::csr_addr_t out_csr_addr,
  output logic                  redirect_valid,
  output rv_isa_pkg::pc_t       redirect_pc
);
  import rv_isa_pkg::*;

  word_t rs1_data;
  word_t rs2_data;
  word_t imm;
  logic  taken;

  decode_ctrl_if ctrl_if ();

  reg_file reg_file_inst (
    .clk      (clk),
    .reset    (reset),
    .rs1      (in_instr[19:15]),
    .rs2      (in_instr[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),       // writeback port
    .rd       (wb_rd),
    .rd_data  (wb_data)
  );

  imm_gen imm_gen_inst (
    .instr (in_instr),
    .imm   (imm)
  );

  branch_compare branch_compare_inst (
    .instr    (in_instr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (taken)
  );

  instr_decoder instr_decoder_inst (
    .instr (in_instr),
    .ctrl  (ctrl_if.decoder)
  );

  decode_control decode_control_inst (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_pc          (in_pc),
    .in_instr       (in_instr),
    .ctrl           (ctrl_if.stage),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .imm            (imm),
    .taken          (taken),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_rs1_data   (out_rs1_data),
    .out_rs2_data   (out_rs2_data),
    .out_imm        (out_imm),
    .out_rd         (out_rd),
    .out_funct3     (out_funct3),
    .out_alu_op     (out_alu_op),
    .out_src_a      (out_src_a),
    .out_src_b      (out_src_b),
    .out_wb_sel     (out_wb_sel),
    .out_reg_we     (out_reg_we),
    .out_mem_read   (out_mem_read),
    .out_mem_write  (out_mem_write),
    .out_csr_we     (out_csr_we),
    .out_csr_addr   (out_csr_addr),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

/* test/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one expected output transfer
typedef struct packed {
  pc_t       pc;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  reg_idx_t  rd;
  funct3_t   funct3;
  alu_op_e   alu_op;
  src_a_e    src_a;
  src_b_e    src_b;
  wb_sel_e   wb_sel;
  logic      reg_we;
  logic      mem_read;
  logic      mem_write;
  logic      csr_we;
  csr_addr_t csr_addr;
} bundle_t;

word_t    shadow_regs [32];
bundle_t  exp_queue [$];  // transfers still owed by the DUT
logic     slot_full;      // expected out_valid
logic     slot_load;      // slot holds a load with rd != 0
reg_idx_t slot_rd;
logic     redir_exp;
pc_t      redir_pc_exp;
logic     squash_now;     // wrong-path cycle

// register read as the stage sees it, writeback shows through
function automatic word_t read_shadow(reg_idx_t idx);
  if (idx == '0) begin
    return '0;
  end
  if (wb_we && wb_rd == idx) begin
    return wb_data;
  end
  return shadow_regs[idx];
endfunction

function automatic word_t format_imm(inst_t instr);
  word_t imm;
  case (instr[6:0])
    op_jalr, op_load, op_imm: imm = $signed(instr) >>> 20;
    op_store: imm = $signed({instr[31:25], instr[11:7], 20'b0}) >>> 20;
    op_branch: imm = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 20'b0}) >>> 19;
    op_lui, op_auipc: imm = {instr[31:12], 12'b0};
    op_jal: imm = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 12'b0}) >>> 11;
    default: imm = '0;
  endcase
  return imm;
endfunction

function automatic logic cond_holds(inst_t instr, word_t a, word_t b);
  word_t sa;
  word_t sb;
  sa = a ^ 32'h8000_0000;  // biased, so signed order becomes unsigned order
  sb = b ^ 32'h8000_0000;
  case (instr[14:12])
    f3_beq:  return a == b;
    f3_bne:  return a != b;
    f3_blt:  return sa < sb;
    f3_bge:  return sa >= sb;
    f3_bltu: return a < b;
    f3_bgeu: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic takes_redirect(inst_t instr);
  case (instr[6:0])
    op_jal, op_jalr: return 1'b1;
    op_branch: return cond_holds(instr, read_shadow(instr[19:15]), read_shadow(instr[24:20]));
    default: return 1'b0;
  endcase
endfunction

function automatic pc_t redirect_target(inst_t instr, pc_t pc);
  word_t sum;
  if (instr[6:0] == op_jalr) begin
    sum = read_shadow(instr[19:15]) + format_imm(instr);
    return sum & ~32'd1;
  end
  return pc + format_imm(instr);
endfunction

// {rs2 read, rs1 read}
function automatic logic [1:0] source_use(inst_t instr);
  case (instr[6:0])
    op_jalr, op_load, op_imm: return 2'b01;
    op_branch, op_store, op_reg: return 2'b11;
    op_system: return (instr[14:12] inside {3'd1, 3'd2, 3'd3}) ? 2'b01 : 2'b00;
    default: return 2'b00;
  endcase
endfunction

function automatic bundle_t decode_expect(inst_t instr, pc_t pc);
  bundle_t b;
  b          = '0;
  b.alu_op   = alu_add;
  b.src_a    = src_a_rs1;
  b.src_b    = src_b_rs2;
  b.wb_sel   = wb_alu;
  b.pc       = pc;
  b.rs1_data = read_shadow(instr[19:15]);
  b.rs2_data = read_shadow(instr[24:20]);
  b.imm      = format_imm(instr);
  b.rd       = instr[11:7];
  b.funct3   = instr[14:12];
  b.csr_addr = instr[31:20];
  case (instr[6:0])
    op_lui: begin
      b.alu_op = alu_pass_b;
      b.src_a  = src_a_zero;
      b.src_b  = src_b_imm;
      b.reg_we = 1'b1;
    end
    op_auipc: begin
      b.src_a  = src_a_pc;
      b.src_b  = src_b_imm;
      b.reg_we = 1'b1;
    end
    op_jal, op_jalr: begin  // link is pc + 4
      b.src_a  = src_a_pc;
      b.src_b  = src_b_four;
      b.wb_sel = wb_pc_plus4;
      b.reg_we = 1'b1;
    end
    op_branch: b.alu_op = alu_sub_cmp;
    op_load: begin
      b.src_b    = src_b_imm;
      b.wb_sel   = wb_mem;
      b.reg_we   = 1'b1;
      b.mem_read = 1'b1;
    end
    op_store: begin
      b.src_b     = src_b_imm;
      b.mem_write = 1'b1;
    end
    op_imm: begin
      b.alu_op = alu_funct;
      b.src_b  = src_b_imm;
      b.reg_we = 1'b1;
    end
    op_reg: begin
      b.alu_op = instr[30] ? alu_sub_cmp : alu_funct;
      b.reg_we = 1'b1;
    end
    op_system: begin
      if (instr[14:12] != 3'd0) begin  // ecall and ebreak do nothing here
        b.wb_sel = wb_csr;
        b.reg_we = 1'b1;
        b.csr_we = 1'b1;
      end
    end
    default: ;
  endcase
  return b;
endfunction

`endif

/* test/decode_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;
  import rv_isa_pkg::*;
  import decode_pkg::*;

  logic      clk;
  logic      reset;
  logic      in_valid;
  logic      in_ready;
  pc_t       in_pc;
  inst_t     in_instr;
  logic      wb_we;
  reg_idx_t  wb_rd;
  word_t     wb_data;
  logic      out_valid;
  logic      out_ready;
  pc_t       out_pc;
  word_t     out_rs1_data;
  word_t     out_rs2_data;
  word_t     out_imm;
  reg_idx_t  out_rd;
  funct3_t   out_funct3;
  alu_op_e   out_alu_op;
  src_a_e    out_src_a;
  src_b_e    out_src_b;
  wb_sel_e   out_wb_sel;
  logic      out_reg_we;
  logic      out_mem_read;
  logic      out_mem_write;
  logic      out_csr_we;
  csr_addr_t out_csr_addr;
  logic      redirect_valid;
  pc_t       redirect_pc;

  int          errors;
  int          checks;
  int          squashed;
  int          transfers;  // bundles taken from the DUT
  int          idle_run;  // cycles with out_valid low since the last transfer
  int          last_gap;
  pc_t         next_pc;
  string       test_name;
  logic [31:0] lfsr_state;

  `include "decode_model.svh"

  decode_stage decode_stage_inst (.*);

  always #5 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic word_t rand_bits(input int n);
    word_t val;
    logic  fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic word_t random_data();
    word_t r;
    word_t kind;
    r    = rand_bits(32);
    kind = rand_bits(2);
    case (kind[1:0])
      2'd0: return {28'd0, r[3:0]};
      2'd1: return {28'hfffffff, r[3:0]};  // small negative
      default: return r;
    endcase
  endfunction

  // registers limited to x0..x7 so hazards and bypasses happen often
  function automatic inst_t random_instr();
    word_t   raw;
    word_t   pick;
    word_t   regs;
    opcode_t op;
    raw  = rand_bits(10);
    pick = rand_bits(4);
    regs = rand_bits(9);
    case (pick[3:0])
      4'd0: op = op_lui;
      4'd1: op = op_auipc;
      4'd2: op = op_jal;
      4'd3: op = op_jalr;
      4'd4, 4'd5: op = op_branch;
      4'd6, 4'd7: op = op_load;
      4'd8: op = op_store;
      4'd9, 4'd10: op = op_imm;
      4'd11, 4'd12: op = op_reg;
      4'd13: op = op_system;
      default: op = 7'b1111111;  // not an rv32i opcode
    endcase
    return {raw[9:3], 2'b00, regs[5:3], 2'b00, regs[2:0], raw[2:0],
            2'b00, regs[8:6], op};
  endfunction

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  task automatic compare_bundle(input bundle_t e);
    check_field("pc", e.pc, out_pc);
    check_field("rs1_data", e.rs1_data, out_rs1_data);
    check_field("rs2_data", e.rs2_data, out_rs2_data);
    check_field("imm", e.imm, out_imm);
    check_field("rd", 32'(e.rd), 32'(out_rd));
    check_field("funct3", 32'(e.funct3), 32'(out_funct3));
    check_field("alu_op", 32'(e.alu_op), 32'(out_alu_op));
    check_field("src_a", 32'(e.src_a), 32'(out_src_a));
    check_field("src_b", 32'(e.src_b), 32'(out_src_b));
    check_field("wb_sel", 32'(e.wb_sel), 32'(out_wb_sel));
    check_field("reg_we", 32'(e.reg_we), 32'(out_reg_we));
    check_field("mem_read", 32'(e.mem_read), 32'(out_mem_read));
    check_field("mem_write", 32'(e.mem_write), 32'(out_mem_write));
    check_field("csr_we", 32'(e.csr_we), 32'(out_csr_we));
    check_field("csr_addr", 32'(e.csr_addr), 32'(out_csr_addr));
  endtask

  // compare this cycle, then advance the model to the next rising edge
  task automatic check_cycle(output logic accepted);
    logic [1:0] uses;
    logic       dep;
    logic       exp_ready;
    logic       go;
    logic       keep;
    bundle_t    nb;
    uses      = source_use(in_instr);
    dep       = (uses[0] && in_instr[19:15] == slot_rd) ||
                (uses[1] && in_instr[24:20] == slot_rd);
    exp_ready = (!slot_full || out_ready) && !(slot_load && dep);
    check_field("out_valid", 32'(slot_full), 32'(out_valid));
    check_field("redirect_valid", 32'(redir_exp), 32'(redirect_valid));
    if (redir_exp && redirect_valid) begin
      check_field("redirect_pc", redir_pc_exp, redirect_pc);
    end
    check_field("in_ready", 32'(exp_ready), 32'(in_ready));
    if (out_valid && out_ready) begin
      transfers++;
      if (exp_queue.size() == 0) begin
        errors++;
        $display("%s: a bundle was presented when none was expected", test_name);
      end else begin
        compare_bundle(exp_queue.pop_front());
      end
      last_gap = idle_run;
      idle_run = 0;
    end else if (!out_valid) begin
      idle_run++;
    end
    go   = in_valid && exp_ready;
    keep = go && !squash_now;
    if (go && squash_now) begin
      squashed++;
    end
    redir_exp = 1'b0;
    if (keep) begin
      nb = decode_expect(in_instr, in_pc);
      exp_queue.push_back(nb);
      redir_exp    = takes_redirect(in_instr);
      redir_pc_exp = redirect_target(in_instr, in_pc);
      slot_load    = nb.mem_read && nb.rd != '0;
      slot_rd      = nb.rd;
    end else if (out_ready) begin
      slot_load = 1'b0;  // slot drains
    end
    slot_full  = keep || (slot_full && !out_ready);
    squash_now = redir_exp;
    if (go) begin
      next_pc = next_pc + 32'd4;
    end
    if (wb_we && wb_rd != '0) begin
      shadow_regs[wb_rd] = wb_data;
    end
    accepted = go;
  endtask

  task automatic run_cycle(input logic valid, input inst_t instr, input logic ready,
                           input logic we, input reg_idx_t rd, input word_t data,
                           output logic accepted);
    @(negedge clk);
    in_valid  = valid;
    in_instr  = instr;
    in_pc     = next_pc;
    out_ready = ready;
    wb_we     = we;
    wb_rd     = rd;
    wb_data   = data;
    #1;  // combinational paths settle
    check_cycle(accepted);
  endtask

  task automatic send_instr(input inst_t instr);
    logic accepted;
    int   waited;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < 20) begin
      run_cycle(1'b1, instr, 1'b1, 1'b0, '0, '0, accepted);
      waited++;
    end
    if (!accepted) begin
      errors++;
      $display("%s: timed out waiting for in_ready on instruction %h", test_name, instr);
    end
  endtask

  task automatic drain_slot();
    logic accepted;
    int   waited;
    waited = 0;
    while ((slot_full || exp_queue.size() != 0) && waited < 20) begin
      run_cycle(1'b0, '0, 1'b1, 1'b0, '0, '0, accepted);
      waited++;
    end
    if (slot_full || exp_queue.size() != 0) begin
      errors++;
      $display("%s: timed out waiting for the output slot to drain", test_name);
    end
  endtask

  initial begin
    word_t ctl;
    word_t rd_pick;
    word_t data;
    inst_t instr;
    logic  acc;
    int    transfers_before;
    clk          = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_instr     = '0;
    out_ready    = 1'b0;
    wb_we        = 1'b0;
    wb_rd        = '0;
    wb_data      = '0;
    errors       = 0;
    checks       = 0;
    squashed     = 0;
    transfers    = 0;
    idle_run     = 0;
    last_gap     = 0;
    next_pc      = 32'h0000_1000;
    lfsr_state   = 32'hea219bae;
    slot_full    = 1'b0;
    slot_load    = 1'b0;
    slot_rd      = '0;
    redir_exp    = 1'b0;
    redir_pc_exp = '0;
    squash_now   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow_regs[i] = '0;
    end

    test_name = "reset";
    repeat (16) @(negedge clk);
    check_field("in_ready", 32'd0, 32'(in_ready));
    check_field("out_valid", 32'd0, 32'(out_valid));
    check_field("redirect_valid", 32'd0, 32'(redirect_valid));
    reset = 1'b0;

    test_name = "random";
    for (int n = 0; n < 4000; n++) begin
      ctl     = rand_bits(5);
      rd_pick = rand_bits(3);
      data    = random_data();
      instr   = random_instr();
      run_cycle(ctl[0] | ctl[1], instr, ctl[2] | ctl[3], ctl[4],
                {2'b00, rd_pick[2:0]}, data, acc);
    end
    drain_slot();

    test_name = "load_use";
    send_instr({12'd8, 5'd1, 3'b010, 5'd5, op_load});       // lw x5, 8(x1)
    send_instr({7'd0, 5'd2, 5'd5, 3'b000, 5'd6, op_reg});   // add x6, x5, x2
    drain_slot();
    check_field("gap", 32'd1, last_gap);

    test_name = "load_independent";
    send_instr({12'd8, 5'd1, 3'b010, 5'd5, op_load});
    send_instr({7'd0, 5'd2, 5'd7, 3'b000, 5'd6, op_reg});   // add x6, x7, x2
    drain_slot();
    check_field("gap", 32'd0, last_gap);

    test_name = "squash";
    transfers_before = transfers;
    send_instr({1'b0, 10'd8, 1'b0, 8'd0, 5'd1, op_jal});    // jal x1, 16
    send_instr({12'd1, 5'd3, 3'b000, 5'd3, op_imm});        // wrong path
    send_instr({12'd2, 5'd3, 3'b000, 5'd3, op_imm});
    drain_slot();
    check_field("transfers", 32'd2, transfers - transfers_before);

    $display("checks %0d, errors %0d, squashed %0d", checks, errors, squashed);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
hdl/rv_isa_pkg.sv
hdl/decode_pkg.sv
hdl/decode_ctrl_if.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/branch_compare.sv
hdl/instr_decoder.sv
hdl/decode_control.sv
hdl/decode_stage.sv
test/decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
  --top-module decode_stage_tb -o decode_stage_sim > build.log 2>&1 &&
./obj_dir/decode_stage_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^Simulation finished: PASS$" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
